//--- vpu_config.svh
`ifndef VPU_CONFIG_SVH
`define VPU_CONFIG_SVH

// lanes per beat, each one word wide
`define VPU_LANES       4
`define VPU_WORD        32

// vector register file entries
`define VPU_RF_DEPTH    16

// beats held by each stream FIFO
`define VPU_FIFO_DEPTH  8

// stages from MAC issue to register file write, at least 2
`define VPU_MAC_LAT     2

`endif

//--- vpu_pkg.sv
`include "vpu_config.svh"

package vpu_pkg;

    // one register file entry or one beat payload
    typedef logic [`VPU_LANES-1:0][`VPU_WORD-1:0] lane_vec_t;

    typedef logic [`VPU_LANES-1:0] lane_mask_t;  // one bit per lane

    typedef logic [$clog2(`VPU_RF_DEPTH)-1:0] rf_addr_t;
    typedef logic [$clog2(`VPU_RF_DEPTH):0]   itr_t;  // 1 .. RF_DEPTH

    typedef struct packed {
        lane_vec_t  data;
        lane_mask_t lane_mask;
        logic       last;
    } stream_beat_t;

    typedef enum logic [1:0] {
        OP_VMV        = 2'd0,
        OP_VMACC      = 2'd1,
        OP_VSTREAMOUT = 2'd2,
        OP_END        = 2'd3
    } vpu_op_e;

    typedef struct packed {
        vpu_op_e  op;
        rf_addr_t vd;
        rf_addr_t vs;
        itr_t     itr;
    } vec_instr_t;

    typedef enum logic {
        STEADY_OFF = 1'b0,
        STEADY_ON  = 1'b1
    } steady_e;

    // register file write port, lanes with a clear mask bit are kept
    typedef struct packed {
        rf_addr_t   wr_addr;
        lane_mask_t wr_mask;
        lane_vec_t  wr_data;
    } rf_wr_t;

endpackage

//--- beat_fifo.sv
`timescale 1ns/1ns

module beat_fifo import vpu_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_push,
    input  stream_beat_t i_din,
    input  logic         i_pop,
    output stream_beat_t o_dout,
    output logic         o_empty,
    output logic         o_full
);

    localparam int AW = $clog2(DEPTH);

    stream_beat_t mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == DEPTH[AW:0]);

    // requests on full or empty are dropped here
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_dout = mem[rd_ptr_q];  // head is visible without a pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- vec_instr_regs.sv
`timescale 1ns/1ns

module vec_instr_regs import vpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_done_loader,
    input  logic       i_instr_valid,
    input  vec_instr_t i_instr,
    input  logic       i_done,
    output vec_instr_t o_instr,
    output logic       o_start,
    output logic       o_busy,
    output logic       o_steady,
    output logic       o_ap_done
);

    steady_e    state_q;
    steady_e    state_d;
    vec_instr_t instr_q;
    logic       busy_q;
    logic       start_q;
    logic       ap_done_q;
    logic       accept;
    logic       accept_end;
    logic       accept_op;

    // instructions are taken only in steady state and while idle
    assign accept     = i_instr_valid && !busy_q && (state_q == STEADY_ON);
    assign accept_end = accept && (i_instr.op == OP_END);
    assign accept_op  = accept && (i_instr.op != OP_END);

    always_comb begin
        state_d = state_q;
        case (state_q)
            STEADY_OFF: begin
                if (i_done_loader) begin
                    state_d = STEADY_ON;
                end
            end
            STEADY_ON: begin
                if (accept_end) begin
                    state_d = STEADY_OFF;  // drops together with ap_done
                end
            end
            default: state_d = STEADY_OFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= STEADY_OFF;
            busy_q    <= 1'b0;
            start_q   <= 1'b0;
            ap_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            start_q   <= accept_op;
            ap_done_q <= accept_end;  // single cycle
            if (accept_op) begin
                busy_q <= 1'b1;
            end else if (i_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // instruction fields stay put until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= i_instr;
        end
    end

    assign o_instr   = instr_q;
    assign o_start   = start_q;  // same cycle as the latched fields
    assign o_busy    = busy_q;
    assign o_steady  = (state_q == STEADY_ON);
    assign o_ap_done = ap_done_q;

endmodule

//--- vec_addr_gen.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vec_addr_gen import vpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_start,
    input  vec_instr_t i_instr,
    input  logic       i_in_empty,
    input  logic       i_out_full,
    input  logic       i_wb_pending,
    output rf_addr_t   o_rd_addr_vd,
    output rf_addr_t   o_rd_addr_vs,
    output logic       o_issue,
    output logic       o_pop_in,
    output logic       o_push_out,
    output logic       o_last,
    output rf_wr_t     o_clr_wr,
    output rf_addr_t   o_wb_addr,
    output logic       o_done
);

    vpu_op_e  op_q;    // OP_END doubles as idle
    vpu_op_e  op_cur;
    itr_t     k_q;
    logic     drain_q;
    logic     step;
    logic     last;
    rf_addr_t vd_k;
    rf_addr_t vs_k;

    // the start cycle already runs index 0
    assign op_cur = i_start ? i_instr.op : op_q;

    assign vd_k = i_instr.vd + rf_addr_t'(k_q);
    assign vs_k = i_instr.vs + rf_addr_t'(k_q);
    assign last = (k_q == itr_t'(i_instr.itr - 1'b1));

    always_comb begin
        case (op_cur)
            OP_VMV:        step = 1'b1;                      // one clear per cycle
            OP_VMACC:      step = !i_in_empty && !drain_q;   // wait for a stream beat
            OP_VSTREAMOUT: step = !i_out_full;               // back-pressure
            default:       step = 1'b0;
        endcase
    end

    // vmacc finishes once the last write reaches the final stage
    assign o_done = (step && last && (op_cur != OP_VMACC)) || (drain_q && !i_wb_pending);

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q    <= OP_END;
            k_q     <= '0;
            drain_q <= 1'b0;
        end else if (o_done) begin
            op_q    <= OP_END;
            k_q     <= '0;
            drain_q <= 1'b0;
        end else begin
            if (i_start) begin
                op_q <= i_instr.op;
            end
            if (step) begin
                if (last) begin
                    k_q     <= '0;
                    drain_q <= (op_cur == OP_VMACC);
                end else begin
                    k_q <= k_q + 1'b1;
                end
            end
        end
    end

    assign o_rd_addr_vd = vd_k;
    assign o_rd_addr_vs = vs_k;
    assign o_wb_addr    = vd_k;  // delayed inside the MAC pipe
    assign o_issue      = step && (op_cur == OP_VMACC);
    assign o_pop_in     = o_issue;  // each MAC index eats one beat
    assign o_push_out   = step && (op_cur == OP_VSTREAMOUT);
    assign o_last       = last;

    assign o_clr_wr.wr_addr = vd_k;
    assign o_clr_wr.wr_mask = {`VPU_LANES{step && (op_cur == OP_VMV)}};
    assign o_clr_wr.wr_data = '0;

endmodule

//--- vec_regfile.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vec_regfile import vpu_pkg::*; (
    input  logic      clk,
    input  rf_addr_t  i_rd_addr1,
    input  rf_addr_t  i_rd_addr2,
    output lane_vec_t o_rd_data1,
    output lane_vec_t o_rd_data2,
    input  rf_wr_t    i_wr
);

    lane_vec_t mem [`VPU_RF_DEPTH];

    // port 1 feeds the accumulator, port 2 the multiplier and stream-out
    assign o_rd_data1 = mem[i_rd_addr1];
    assign o_rd_data2 = mem[i_rd_addr2];

    always_ff @(posedge clk) begin
        for (int l = 0; l < `VPU_LANES; l++) begin
            if (i_wr.wr_mask[l]) begin
                mem[i_wr.wr_addr][l] <= i_wr.wr_data[l];  // masked lanes keep old value
            end
        end
    end

endmodule

//--- vmacc_pipe.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vmacc_pipe import vpu_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_issue,
    input  stream_beat_t i_beat,
    input  lane_vec_t    i_acc,
    input  lane_vec_t    i_mul,
    input  rf_addr_t     i_wb_addr,
    output rf_wr_t       o_wr,
    output logic         o_wb_pending
);

    localparam int LAT = `VPU_MAC_LAT;

    logic [LAT-1:0] vld_q;
    lane_vec_t      acc_q;
    lane_vec_t      prod_q;
    lane_mask_t     mask_q;
    rf_addr_t       addr_q;
    lane_vec_t      prod_d;
    rf_wr_t         st_q [1:LAT-1];  // add stage, then plain delay stages

    always_comb begin
        for (int l = 0; l < `VPU_LANES; l++) begin
            prod_d[l] = i_beat.data[l] * i_mul[l];  // low 32 bits only
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAT-2:0], i_issue};
        end
    end

    always_ff @(posedge clk) begin
        acc_q  <= i_acc;
        prod_q <= prod_d;
        mask_q <= i_beat.lane_mask;
        addr_q <= i_wb_addr;
        st_q[1].wr_addr <= addr_q;
        st_q[1].wr_mask <= mask_q;
        for (int l = 0; l < `VPU_LANES; l++) begin
            st_q[1].wr_data[l] <= acc_q[l] + prod_q[l];
        end
        for (int s = 2; s < LAT; s++) begin
            st_q[s] <= st_q[s-1];
        end
    end

    assign o_wr.wr_addr = st_q[LAT-1].wr_addr;
    assign o_wr.wr_data = st_q[LAT-1].wr_data;
    assign o_wr.wr_mask = st_q[LAT-1].wr_mask & {`VPU_LANES{vld_q[LAT-1]}};

    // the final stage writes this cycle, so it is not pending
    assign o_wb_pending = |vld_q[LAT-2:0];

endmodule

//--- vpu_top.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vpu_top import vpu_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_done_loader,
    input  logic                              i_instr_valid,
    input  vec_instr_t                        i_instr,
    output logic                              o_busy,
    output logic                              o_steady,
    output logic                              o_ap_done,
    // stream in
    input  logic [`VPU_LANES*`VPU_WORD-1:0]   i_tdata,
    input  logic [`VPU_LANES*`VPU_WORD/8-1:0] i_tkeep,
    input  logic                              i_tvalid,
    input  logic                              i_tlast,
    output logic                              o_tready,
    // stream out
    output logic [`VPU_LANES*`VPU_WORD-1:0]   o_tdata,
    output logic [`VPU_LANES*`VPU_WORD/8-1:0] o_tkeep,
    output logic                              o_tvalid,
    output logic                              o_tlast,
    input  logic                              i_tready
);

    localparam int KB = `VPU_WORD / 8;  // keep bits per lane

    stream_beat_t in_beat, in_head, out_beat, out_head;
    logic         in_empty, in_full, out_empty, out_full;
    logic         pop_in, push_out, issue, last, start, done, wb_pending;
    vec_instr_t   instr;
    rf_addr_t     rd_addr_vd, rd_addr_vs, wb_addr;
    lane_vec_t    rd_data1, rd_data2;
    rf_wr_t       clr_wr, mac_wr, rf_wr;

    // a lane counts only with all of its keep bits set
    always_comb begin
        in_beat.data = i_tdata;
        in_beat.last = i_tlast;
        for (int l = 0; l < `VPU_LANES; l++) begin
            in_beat.lane_mask[l] = &i_tkeep[l*KB +: KB];
        end
    end

    assign o_tready = o_steady && !in_full;

    beat_fifo #(.DEPTH(`VPU_FIFO_DEPTH)) u_in_fifo (
        .clk(clk), .rst(rst),
        .i_push(i_tvalid && o_tready), .i_din(in_beat),
        .i_pop(pop_in), .o_dout(in_head),
        .o_empty(in_empty), .o_full(in_full)
    );

    vec_instr_regs u_instr_regs (
        .clk(clk), .rst(rst),
        .i_done_loader(i_done_loader), .i_instr_valid(i_instr_valid),
        .i_instr(i_instr), .i_done(done),
        .o_instr(instr), .o_start(start), .o_busy(o_busy),
        .o_steady(o_steady), .o_ap_done(o_ap_done)
    );

    vec_addr_gen u_addr_gen (
        .clk(clk), .rst(rst),
        .i_start(start), .i_instr(instr),
        .i_in_empty(in_empty), .i_out_full(out_full), .i_wb_pending(wb_pending),
        .o_rd_addr_vd(rd_addr_vd), .o_rd_addr_vs(rd_addr_vs),
        .o_issue(issue), .o_pop_in(pop_in), .o_push_out(push_out), .o_last(last),
        .o_clr_wr(clr_wr), .o_wb_addr(wb_addr), .o_done(done)
    );

    // one op at a time, so the two write sources never collide
    assign rf_wr.wr_mask = clr_wr.wr_mask | mac_wr.wr_mask;
    assign rf_wr.wr_addr = (|clr_wr.wr_mask) ? clr_wr.wr_addr : mac_wr.wr_addr;
    assign rf_wr.wr_data = (|clr_wr.wr_mask) ? clr_wr.wr_data : mac_wr.wr_data;

    vec_regfile u_regfile (
        .clk(clk),
        .i_rd_addr1(rd_addr_vd), .i_rd_addr2(rd_addr_vs),
        .o_rd_data1(rd_data1), .o_rd_data2(rd_data2),
        .i_wr(rf_wr)
    );

    vmacc_pipe u_mac (
        .clk(clk), .rst(rst),
        .i_issue(issue), .i_beat(in_head),
        .i_acc(rd_data1), .i_mul(rd_data2), .i_wb_addr(wb_addr),
        .o_wr(mac_wr), .o_wb_pending(wb_pending)
    );

    assign out_beat.data      = rd_data2;  // vs[k]
    assign out_beat.lane_mask = '1;
    assign out_beat.last      = last;

    beat_fifo #(.DEPTH(`VPU_FIFO_DEPTH)) u_out_fifo (
        .clk(clk), .rst(rst),
        .i_push(push_out), .i_din(out_beat),
        .i_pop(i_tready), .o_dout(out_head),
        .o_empty(out_empty), .o_full(out_full)
    );

    assign o_tvalid = !out_empty;
    assign o_tdata  = out_head.data;
    assign o_tlast  = out_head.last;

    always_comb begin
        for (int l = 0; l < `VPU_LANES; l++) begin
            o_tkeep[l*KB +: KB] = {KB{out_head.lane_mask[l]}};
        end
    end

endmodule

//--- vpu_props.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vpu_props (
    input logic                            clk,
    input logic                            rst,
    input logic                            i_ap_done,
    input logic                            i_busy,
    input logic                            i_tvalid,
    input logic                            i_tready,
    input logic [`VPU_LANES*`VPU_WORD-1:0] i_tdata
);

    int assert_fails = 0;  // watched by the testbench

    ap_done_single: assert property (@(posedge clk) disable iff (rst)
        i_ap_done |=> !i_ap_done)
    else begin
        $error("ap_done held high for more than one cycle");
        assert_fails++;
    end

    // a stalled output beat must not move or change
    out_hold: assert property (@(posedge clk) disable iff (rst)
        i_tvalid && !i_tready |=> i_tvalid && $stable(i_tdata))
    else begin
        $error("output beat changed while i_tready was low");
        assert_fails++;
    end

    busy_after_reset: assert property (@(posedge clk) rst |=> !i_busy)
    else begin
        $error("busy high right after reset");
        assert_fails++;
    end

endmodule

bind vpu_top vpu_props u_props (
    .clk(clk), .rst(rst), .i_ap_done(o_ap_done), .i_busy(o_busy),
    .i_tvalid(o_tvalid), .i_tready(i_tready), .i_tdata(o_tdata)
);

//--- tb_vpu.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module tb_vpu
    import vpu_pkg::*;
();

    localparam int KW      = `VPU_LANES * `VPU_WORD / 8;
    localparam int REC_W   = 7;   // words per line of the data file
    localparam int REC_MAX = 32;

    typedef struct packed {
        lane_vec_t     data;
        logic [KW-1:0] keep;
        logic          last;
    } axis_rec_t;

    logic clk = 1'b0;
    logic rst;
    logic i_done_loader, i_instr_valid, i_tvalid, i_tlast, i_tready;
    vec_instr_t i_instr;
    logic o_busy, o_steady, o_ap_done, o_tready, o_tvalid, o_tlast;
    logic [`VPU_LANES*`VPU_WORD-1:0] i_tdata, o_tdata;
    logic [KW-1:0] i_tkeep, o_tkeep;

    logic [31:0] words [REC_MAX*REC_W];
    vec_instr_t  instr_q [$];
    axis_rec_t   in_q [$];
    axis_rec_t   exp_q [$];
    logic [31:0] lfsr_q = 32'h0d2c_8edb;
    int          cycles = 0;
    int          limit = 200;

    vpu_top i_vpu_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // lane is live only with all of its keep bits
    function automatic lane_mask_t keep_to_mask(input logic [KW-1:0] keep);
        lane_mask_t m;
        for (int l = 0; l < `VPU_LANES; l++) begin
            m[l] = &keep[l*KW/`VPU_LANES +: KW/`VPU_LANES];
        end
        return m;
    endfunction

    task automatic check_beat(input stream_beat_t got, input stream_beat_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "beat mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic load_vectors();
        int         b;
        int         entries;
        vec_instr_t ins;
        axis_rec_t  rec;
        entries = 0;
        for (int i = 0; i < REC_MAX*REC_W; i++) begin
            words[i] = '0;
        end
        $readmemh("vpu_input.txt", words);
        for (int r = 0; r < REC_MAX && words[r*REC_W] != 0; r++) begin
            b = r * REC_W;
            if (words[b] == 1) begin
                ins.op  = vpu_op_e'(words[b+1][1:0]);
                ins.vd  = rf_addr_t'(words[b+2]);
                ins.vs  = rf_addr_t'(words[b+3]);
                ins.itr = itr_t'(words[b+4]);
                entries += ins.itr;
                instr_q.push_back(ins);
            end else begin
                rec.keep = words[b+1][KW-1:0];
                rec.last = words[b+2][0];
                for (int l = 0; l < `VPU_LANES; l++) begin
                    rec.data[l] = words[b + 2 + `VPU_LANES - l];  // highest lane first
                end
                if (words[b] == 2) begin
                    in_q.push_back(rec);
                end else begin
                    exp_q.push_back(rec);
                end
            end
        end
        limit = 20 * (in_q.size() + exp_q.size() + entries) + 200;
    endtask

    task automatic drive_instrs();
        foreach (instr_q[i]) begin
            do @(posedge clk); while (o_busy || !o_steady);
            i_instr       <= instr_q[i];
            i_instr_valid <= 1'b1;
            @(posedge clk);
            i_instr_valid <= 1'b0;
            @(posedge clk);
            check_flag(o_busy, instr_q[i].op != OP_END, "busy after accept");
            if (instr_q[i].op == OP_END) begin
                check_flag(o_ap_done, 1'b1, "ap_done pulse");
                check_flag(o_steady, 1'b0, "steady after end");
                @(posedge clk);
                check_flag(o_ap_done, 1'b0, "ap_done width");
            end
        end
    endtask

    task automatic drive_stream();
        do @(posedge clk); while (!o_steady);
        foreach (in_q[i]) begin
            i_tdata  <= in_q[i].data;
            i_tkeep  <= in_q[i].keep;
            i_tlast  <= in_q[i].last;
            i_tvalid <= 1'b1;
            do @(posedge clk); while (!o_tready);
        end
        i_tvalid <= 1'b0;
    endtask

    task automatic check_stream();
        stream_beat_t got;
        stream_beat_t exp;
        foreach (exp_q[i]) begin
            do @(posedge clk); while (!(o_tvalid && i_tready));
            got.data      = o_tdata;
            got.lane_mask = keep_to_mask(o_tkeep);
            got.last      = o_tlast;
            exp.data      = exp_q[i].data;
            exp.lane_mask = keep_to_mask(exp_q[i].keep);
            exp.last      = exp_q[i].last;
            check_beat(got, exp, $sformatf("output beat %0d", i));
            check_flag(o_tkeep == exp_q[i].keep, 1'b1, "tkeep pattern");
        end
    endtask

    // sink ready about one cycle in eight, so the output FIFO fills up
    always @(posedge clk) begin : sink_ready
        logic ready;
        ready = 1'b1;
        for (int n = 0; n < 3; n++) begin
            lfsr_q = lfsr_next(lfsr_q);
            ready  = ready & lfsr_q[0];
        end
        i_tready <= ready;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $fatal(1, "timeout");
        end else if (i_vpu_top.u_props.assert_fails != 0) begin
            $display("a bound assertion on the DUT failed at %0t", $time);
            $display("Regression failed");
            $fatal(1, "assertion");
        end
    end

    initial begin
        rst           = 1'b1;
        i_done_loader = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_tdata       = '0;
        i_tkeep       = '0;
        i_tvalid      = 1'b0;
        i_tlast       = 1'b0;
        i_tready      = 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag(o_busy, 1'b0, "busy after reset");
        check_flag(o_ap_done, 1'b0, "ap_done after reset");
        check_flag(o_tvalid, 1'b0, "tvalid after reset");
        check_flag(o_tready, 1'b0, "tready after reset");
        check_flag(o_steady, 1'b0, "steady after reset");
        i_done_loader <= 1'b1;
        @(posedge clk);
        i_done_loader <= 1'b0;
        check_flag(o_steady, 1'b0, "steady during loader pulse");
        @(posedge clk);
        check_flag(o_steady, 1'b1, "steady after loader");
        check_flag(o_tready, 1'b1, "tready after loader");  // input FIFO still empty
        fork
            drive_instrs();
            drive_stream();
            check_stream();
        join
        if (i_vpu_top.u_props.assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vpu_input.txt
// kind 1 instruction: op vd vs itr 0 0 (op 0 vmv, 1 vmacc, 2 vstreamout, 3 end)
// kind 2 input beat, kind 3 expected output beat: keep last lane3 lane2 lane1 lane0
1 0 0 0 a 0 0
1 1 0 6 2 0 0
1 1 0 6 2 0 0
1 2 0 0 a 0 0
1 3 0 0 1 0 0
2 ffff 0 00000004 00000003 00000002 00000001
2 ffff 1 0000000d 7fffffff 80000000 ffffffff
2 ffff 0 00001234 00000010 deadbeef 00000005
2 ff0f 1 00000002 00000009 0badf00d 00000003
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 0 00000000 00000000 00000000 00000000
3 ffff 1 00000000 00000000 00000000 00000000

//--- compile.f
+incdir+.
vpu_pkg.sv
beat_fifo.sv
vec_instr_regs.sv
vec_addr_gen.sv
vec_regfile.sv
vmacc_pipe.sv
vpu_top.sv
vpu_props.sv
tb_vpu.sv
